// ==== include/apb_delay_defines.svh ====
`ifndef APB_DELAY_DEFINES_SVH
`define APB_DELAY_DEFINES_SVH

// 1 scales the target latency, 0 turns the delayer into plain wires
`define PMU_ON 1

`endif

// ==== hw/apb_delay_pkg.sv ====
`default_nettype none

package apb_delay_pkg;

    localparam int unsigned ADDR_W  = 32;
    localparam int unsigned DATA_W  = 32;
    localparam int unsigned STRB_W  = DATA_W / 8;
    localparam int unsigned COUNT_W = 32;

    // Delay ratio 1.5 in fixed point with SCALE_SHIFT fraction bits
    localparam int unsigned SCALE_SHIFT = 10;
    localparam logic [COUNT_W-1:0] DELAY_RATIO_Q = COUNT_W'(1536);

    localparam int unsigned MEM_WORDS = 64;
    localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);   // Word index bits
    localparam logic [ADDR_W-1:0] WAIT_REG_ADDR = 32'h0000_0100;
    localparam int unsigned WAIT_W    = 4;

    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              psel;
        logic              penable;
        logic [2:0]        pprot;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
        logic [STRB_W-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        logic [DATA_W-1:0] prdata;
        logic              pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        DLY_IDLE,
        DLY_ACTIVE,   // Target is stalling, stall time accumulates
        DLY_HOLD      // Counting the extra cycles down
    } delay_state_e;

    typedef enum logic [1:0] {
        TGT_IDLE,
        TGT_WAIT,
        TGT_DONE      // Answered, ignores penable until the next setup
    } target_state_e;

endpackage

`default_nettype wire

// ==== hw/apb_delayer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "apb_delay_defines.svh"

module apb_delayer
    import apb_delay_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire apb_req_t in_req,
    output apb_rsp_t      in_rsp,
    output apb_req_t      out_req,
    input  wire apb_rsp_t out_rsp
);

    // The request side is never touched, only the completion is moved
    assign out_req = in_req;

    if (`PMU_ON) begin : g_scale
        delay_state_e       state_q;
        logic [COUNT_W-1:0] acc_q;       // Scaled stall time, then whole cycles left
        logic [DATA_W-1:0]  rdata_q;
        logic               slverr_q;
        apb_rsp_t           rsp_q;
        logic               setup;
        logic               release_now;

        assign setup = in_req.psel && !in_req.penable;

        // Last hold cycle, the response goes out on the next edge
        assign release_now = (state_q == DLY_HOLD) && (acc_q == '0);

        always_ff @(posedge clock) begin
            if (reset) begin
                state_q <= DLY_IDLE;
            end else if (setup) begin
                state_q <= DLY_ACTIVE;
            end else begin
                case (state_q)
                    DLY_ACTIVE: begin
                        if (out_rsp.pready) begin
                            state_q <= DLY_HOLD;
                        end
                    end
                    DLY_HOLD: begin
                        if (acc_q == '0) begin
                            state_q <= DLY_IDLE;
                        end
                    end
                    default: begin
                        state_q <= DLY_IDLE;
                    end
                endcase
            end
        end

        always_ff @(posedge clock) begin
            if (reset) begin
                acc_q <= '0;
            end else if (setup) begin
                acc_q <= '0;
            end else if (state_q == DLY_ACTIVE) begin
                if (out_rsp.pready) begin
                    // Drop the fraction bits to get whole extra cycles
                    acc_q <= acc_q >> SCALE_SHIFT;
                end else begin
                    acc_q <= acc_q + DELAY_RATIO_Q;
                end
            end else if (state_q == DLY_HOLD && acc_q != '0) begin
                acc_q <= acc_q - 1'b1;
            end
        end

        // Target answer is kept here while the requester is held off
        always_ff @(posedge clock) begin
            if (state_q == DLY_ACTIVE && out_rsp.pready) begin
                rdata_q  <= out_rsp.prdata;
                slverr_q <= out_rsp.pslverr;
            end
        end

        always_ff @(posedge clock) begin
            if (reset) begin
                rsp_q <= '0;
            end else begin
                rsp_q.pready  <= release_now;
                rsp_q.prdata  <= release_now ? rdata_q : '0;
                rsp_q.pslverr <= release_now && slverr_q;
            end
        end

        assign in_rsp = rsp_q;
    end else begin : g_bypass
        assign in_rsp = out_rsp;   // Target latency is seen as is
    end

endmodule

`default_nettype wire

// ==== hw/apb_wait_target.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_wait_target
    import apb_delay_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire apb_req_t req,
    output apb_rsp_t      rsp
);

    target_state_e     state_q;
    logic [WAIT_W-1:0] wait_q;         // Programmed wait states
    logic [WAIT_W-1:0] count_q;        // Wait cycles left in this transfer
    logic [DATA_W-1:0] mem_q [MEM_WORDS];

    logic              setup;
    logic              access;
    logic              done;
    logic              is_mem;
    logic              is_wait;
    logic              is_err;
    logic [MEM_AW-1:0] word_idx;
    logic [DATA_W-1:0] merged;

    assign setup  = req.psel && !req.penable;
    assign access = req.psel && req.penable;

    // Single cycle in which the transfer completes
    assign done = (state_q == TGT_WAIT) && access && (count_q == '0);

    // 0x000-0x0FC memory, 0x100 wait register, everything above is an error
    assign is_mem   = req.paddr[ADDR_W-1:2] < MEM_WORDS;
    assign is_wait  = req.paddr[ADDR_W-1:2] == WAIT_REG_ADDR[ADDR_W-1:2];
    assign is_err   = !is_mem && !is_wait;
    assign word_idx = req.paddr[MEM_AW+1:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= TGT_IDLE;
            count_q <= '0;
        end else if (setup) begin
            state_q <= TGT_WAIT;
            count_q <= wait_q;             // Wait count is taken at setup
        end else if (state_q == TGT_WAIT && access) begin
            if (count_q == '0) begin
                state_q <= TGT_DONE;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_comb begin
        merged = mem_q[word_idx];
        for (int b = 0; b < STRB_W; b++) begin
            if (req.pstrb[b]) begin
                merged[b*8 +: 8] = req.pwdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (done && req.pwrite && is_mem) begin
            mem_q[word_idx] <= merged;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wait_q <= '0;
        end else if (done && req.pwrite && is_wait) begin
            wait_q <= req.pwdata[WAIT_W-1:0];  // Strobes do not apply here
        end
    end

    always_comb begin
        rsp = '0;
        rsp.pready = done;
        rsp.pslverr = done && is_err;
        if (done && !req.pwrite) begin
            if (is_mem) begin
                rsp.prdata = mem_q[word_idx];
            end else if (is_wait) begin
                rsp.prdata = DATA_W'(wait_q);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/apb_delay_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_delay_top
    import apb_delay_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire apb_req_t req,
    output apb_rsp_t      rsp
);

    // Link between the delayer and the slow target
    apb_req_t tgt_req;
    apb_rsp_t tgt_rsp;

    apb_delayer u_delayer (
        .clock   (clock),
        .reset   (reset),
        .in_req  (req),
        .in_rsp  (rsp),
        .out_req (tgt_req),
        .out_rsp (tgt_rsp)
    );

    apb_wait_target u_target (
        .clock (clock),
        .reset (reset),
        .req   (tgt_req),
        .rsp   (tgt_rsp)
    );

endmodule

`default_nettype wire

// ==== tb/apb_delay_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "apb_delay_defines.svh"

module apb_delay_tb
    import apb_delay_pkg::*;
;

    localparam logic [ADDR_W-1:0] ERR_BASE = WAIT_REG_ADDR + 32'd4;
    localparam int MAX_TRANSFERS = 270;
    localparam int WORST_TRANSFER = 2 + 15 + 22 + 4;   // Setup, wait, hold, return
    localparam int CYCLE_LIMIT = MAX_TRANSFERS * WORST_TRANSFER + 8 + 200;

    logic     clock = 1'b0;
    logic     reset;
    apb_req_t req;
    apb_rsp_t rsp;

    int seed = 32'h64011625;
    int cycle_count = 0;
    int checks = 0;
    int errors = 0;
    int test_checks;
    int test_errors;

    logic [DATA_W-1:0] shadow_mem [MEM_WORDS];
    logic [WAIT_W-1:0] shadow_wait;

    apb_rsp_t exp_rsp_q [$];
    apb_rsp_t got_rsp_q [$];
    int       exp_lat_q [$];
    int       got_lat_q [$];
    string    tag_q [$];
    event     xfer_done;

    apb_delay_top u_dut (
        .clock (clock),
        .reset (reset),
        .req   (req),
        .rsp   (rsp)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Memory sits below 0x100, the wait register at 0x100 and errors from 0x104 up
    function automatic apb_rsp_t expected_response(input logic [ADDR_W-1:0] addr,
                                                   input logic write);
        apb_rsp_t r;
        r = '0;
        r.pready = 1'b1;
        if (addr >= ERR_BASE) begin
            r.pslverr = 1'b1;
        end else if (!write && addr < WAIT_REG_ADDR) begin
            r.prdata = shadow_mem[addr[7:2]];
        end else if (!write) begin
            r.prdata = DATA_W'(shadow_wait);
        end
        return r;
    endfunction

    function automatic int expected_latency(input int w);
        if (`PMU_ON) begin
            return w + ((w * 1536) / 1024) + 2;
        end
        return w;
    endfunction

    task automatic model_update(input logic [ADDR_W-1:0] addr, input logic write,
                                input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
        if (write && addr < WAIT_REG_ADDR) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) begin
                    shadow_mem[addr[7:2]][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end else if (write && addr == WAIT_REG_ADDR) begin
            shadow_wait = wdata[WAIT_W-1:0];
        end
    endtask

    task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s pready/prdata/pslverr %b/%h/%b, expected %b/%h/%b",
                     $time, what, got.pready, got.prdata, got.pslverr,
                     exp.pready, exp.prdata, exp.pslverr);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error at %0t ns: %s latency %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    // Runs one APB transfer and counts the cycles from the first access cycle to pready
    task automatic apb_transfer(input logic [ADDR_W-1:0] addr, input logic write,
                                input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                                input logic [2:0] prot, output apb_rsp_t got, output int cycles);
        @(posedge clock);
        #1;
        req.paddr = addr;
        req.pwrite = write;
        req.pwdata = wdata;
        req.pstrb = strb;
        req.pprot = prot;
        req.psel = 1'b1;
        req.penable = 1'b0;
        @(posedge clock);
        #1;
        req.penable = 1'b1;
        cycles = 0;
        @(negedge clock);
        while (!rsp.pready) begin
            cycles++;
            @(negedge clock);
        end
        got = rsp;
        @(posedge clock);
        #1;
        req.psel = 1'b0;
        req.penable = 1'b0;
    endtask

    task automatic run_transfer(input logic [ADDR_W-1:0] addr, input logic write,
                                input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                                input logic [2:0] prot);
        apb_rsp_t got;
        int cycles;
        exp_rsp_q.push_back(expected_response(addr, write));
        exp_lat_q.push_back(expected_latency(int'(shadow_wait)));
        tag_q.push_back($sformatf("%s at %h", write ? "write" : "read", addr));
        apb_transfer(addr, write, wdata, strb, prot, got, cycles);
        model_update(addr, write, wdata, strb);
        got_rsp_q.push_back(got);
        got_lat_q.push_back(cycles);
        -> xfer_done;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb);
        run_transfer(addr, 1'b1, data, strb, 3'b000);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr);
        run_transfer(addr, 1'b0, '0, '0, 3'b000);
    endtask

    always @(xfer_done) begin
        while (got_rsp_q.size() > 0) begin
            check_rsp(got_rsp_q.pop_front(), exp_rsp_q.pop_front(), tag_q[0]);
            check_latency(got_lat_q.pop_front(), exp_lat_q.pop_front(), tag_q.pop_front());
        end
    end

    task automatic begin_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        @(posedge clock);   // Lets the compare process drain its queues
        $display("test %s: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
    endtask

    initial begin
        logic [ADDR_W-1:0] mem_addrs [6];
        logic [STRB_W-1:0] strbs [5];
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic [2:0]        prot;
        logic              write;
        int unsigned       kind;

        mem_addrs = '{32'h000, 32'h004, 32'h040, 32'h080, 32'h0F8, 32'h0FC};
        strbs = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
        req = '0;
        reset = 1'b1;
        shadow_wait = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow_mem[i] = '0;
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        begin_test();
        @(negedge clock);
        check_rsp(rsp, apb_rsp_t'('0), "response after reset");
        read_word(WAIT_REG_ADDR);
        end_test("reset");

        begin_test();
        for (int i = 0; i < 6; i++) begin
            write_word(mem_addrs[i], $random(seed), 4'b1111);
            read_word(mem_addrs[i]);
        end
        end_test("full word write and read");

        // Merges land on words that already hold data
        begin_test();
        for (int i = 0; i < 5; i++) begin
            write_word(mem_addrs[i + 1], $random(seed), strbs[i]);
            read_word(mem_addrs[i + 1]);
        end
        end_test("byte strobes");

        begin_test();
        for (int w = 1; w <= 15; w++) begin
            write_word(WAIT_REG_ADDR, DATA_W'(w), 4'b1111);
            read_word(ADDR_W'(w * 4));
        end
        write_word(WAIT_REG_ADDR, '0, 4'b1111);
        read_word(WAIT_REG_ADDR);
        end_test("wait states");

        // 0x104 and 0x200 share their low address bits with words 1 and 0
        begin_test();
        write_word(ERR_BASE, $random(seed), 4'b1111);
        read_word(ERR_BASE);
        write_word(32'h0000_0200, $random(seed), 4'b1111);
        read_word(32'hFFFF_FFFC);
        read_word(32'h004);
        read_word(32'h000);
        end_test("error addresses");

        begin_test();
        for (int n = 0; n < 200; n++) begin
            kind = $unsigned($random(seed)) % 8;
            if (kind < 6) begin
                addr = ADDR_W'(($unsigned($random(seed)) % MEM_WORDS) * 4);
            end else if (kind == 6) begin
                addr = WAIT_REG_ADDR;
            end else begin
                addr = ($random(seed) | ERR_BASE) & 32'hFFFF_FFFC;
            end
            write = $random(seed);
            data = $random(seed);
            strb = write ? STRB_W'($random(seed)) : '0;
            prot = $random(seed);
            run_transfer(addr, write, write ? data : '0, strb, prot);
        end
        end_test("random transfers");

        repeat (2) @(posedge clock);
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hw/apb_delay_pkg.sv
hw/apb_delayer.sv
hw/apb_wait_target.sv
hw/apb_delay_top.sv
tb/apb_delay_tb.sv

// ==== Bender.yml ====
package:
  name: apb_delay

export_include_dirs:
  - include

sources:
  - files:
      - hw/apb_delay_pkg.sv
      - hw/apb_delayer.sv
      - hw/apb_wait_target.sv
      - hw/apb_delay_top.sv
  - target: test
    files:
      - tb/apb_delay_tb.sv
